// ==== Makefile ====
# Verilator flow for the block transposer testbench.

VERILATOR ?= verilator
TOP       ?= tb_block_transposer
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# the pass line in the simulation output decides the exit status.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/block_transposer.sv ====
`timescale 1ns/1ps

module block_transposer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  block_transposer_pkg::sample_t in_s,
    output block_transposer_pkg::sample_t out_s
);

    block_transposer_pkg::elem_idx_t idx;
    logic                            last;
    block_transposer_pkg::steer_t    steer;

    // position of the incoming sample within its block.
    elem_counter elem_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (in_s.valid),
        .idx   (idx),
        .last  (last)
    );

    // fill tracking and write-order flip.
    transpose_ctrl transpose_ctrl_i (
        .clk   (clk),
        .rst_n (rst_n),
        .last  (last),
        .steer (steer)
    );

    // single buffer, read before write.
    transpose_ram transpose_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (in_s),
        .idx   (idx),
        .steer (steer),
        .out_s (out_s)
    );

endmodule

// ==== design/block_transposer_macros.svh ====
`ifndef BLOCK_TRANSPOSER_MACROS_SVH
`define BLOCK_TRANSPOSER_MACROS_SVH

// side of a square block, in samples.
`define BT_BLK_DIM 8

// sample word width.
`define BT_DATA_W 16

// width of one row or column coordinate.
`define BT_DIM_W 3
`define BT_IDX_W 6   // row and column together.

`endif

// ==== design/block_transposer_pkg.sv ====
`include "block_transposer_macros.svh"

package block_transposer_pkg;

    // one sample word.
    typedef logic [`BT_DATA_W-1:0] data_t;

    // element position in arrival order, row in the upper bits.
    typedef logic [`BT_IDX_W-1:0] elem_idx_t;

    // strobe plus payload, used on both sides of the transposer.
    typedef struct packed {
        logic  valid;
        data_t data;
    } sample_t;

    // memory steering from the controller.
    typedef struct packed {
        logic orient;   // set: row and column swapped.
        logic primed;   // a full block sits in the memory.
    } steer_t;

    // controller states.
    typedef enum logic {
        FILL   = 1'b0,
        STREAM = 1'b1
    } ctrl_state_e;

endpackage

// ==== design/elem_counter.sv ====
`timescale 1ns/1ps
`include "block_transposer_macros.svh"

module elem_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           step,
    output block_transposer_pkg::elem_idx_t idx,
    output logic                           last
);

    localparam block_transposer_pkg::elem_idx_t LAST_IDX =
        block_transposer_pkg::elem_idx_t'(`BT_BLK_DIM * `BT_BLK_DIM - 1);

    block_transposer_pkg::elem_idx_t idx_q;
    block_transposer_pkg::elem_idx_t idx_nxt;

    // final element of the block while it is being accepted.
    assign last = step && (idx_q == LAST_IDX);

    always_comb
    begin
        idx_nxt = idx_q;
        if (last)
        begin
            idx_nxt = '0;   // wrap to the next block.
        end
        else if (step)
        begin
            idx_nxt = idx_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx_q <= '0;
        end
        else
        begin
            idx_q <= idx_nxt;
        end
    end

    assign idx = idx_q;

    // block end can only be flagged on an accepted sample.
    last_needs_step_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(last) |-> step
    );

endmodule

// ==== design/transpose_ctrl.sv ====
`timescale 1ns/1ps

module transpose_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         last,
    output block_transposer_pkg::steer_t steer
);

    block_transposer_pkg::ctrl_state_e state_q;
    block_transposer_pkg::ctrl_state_e state_nxt;
    logic                              orient_q;
    logic                              orient_nxt;

    always_comb
    begin
        state_nxt  = state_q;
        orient_nxt = orient_q;
        if (last)
        begin
            // each block end flips the write order for the next block.
            orient_nxt = ~orient_q;
            if (state_q == block_transposer_pkg::FILL)
            begin
                state_nxt = block_transposer_pkg::STREAM;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q  <= block_transposer_pkg::FILL;
            orient_q <= 1'b0;
        end
        else
        begin
            state_q  <= state_nxt;
            orient_q <= orient_nxt;
        end
    end

    assign steer.orient = orient_q;
    assign steer.primed = (state_q == block_transposer_pkg::STREAM);   // no way back to FILL.

    // orientation only moves right after a block end.
    orient_after_last_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(steer.orient) |-> $past(last)
    );

endmodule

// ==== design/transpose_ram.sv ====
`timescale 1ns/1ps
`include "block_transposer_macros.svh"

module transpose_ram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  block_transposer_pkg::sample_t   in_s,
    input  block_transposer_pkg::elem_idx_t idx,
    input  block_transposer_pkg::steer_t    steer,
    output block_transposer_pkg::sample_t   out_s
);

    localparam int DEPTH = `BT_BLK_DIM * `BT_BLK_DIM;

    block_transposer_pkg::data_t     mem [DEPTH];
    block_transposer_pkg::elem_idx_t addr;
    logic [`BT_DIM_W-1:0]            row;
    logic [`BT_DIM_W-1:0]            col;
    block_transposer_pkg::data_t     rd_data_q;
    logic                            rd_valid_q;

    // split the arrival index into its coordinates.
    assign row = idx[`BT_IDX_W-1 -: `BT_DIM_W];
    assign col = idx[`BT_DIM_W-1:0];

    // column-major when orient is set.
    assign addr = steer.orient ? {col, row} : {row, col};

    // old word leaves and new word lands on the same edge.
    always_ff @(posedge clk)
    begin
        if (in_s.valid)
        begin
            mem[addr] <= in_s.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_data_q <= '0;
        end
        else if (in_s.valid)
        begin
            rd_data_q <= mem[addr];   // pre-write contents.
        end
    end

    // nothing real to send until a whole block is stored.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= in_s.valid && steer.primed;
        end
    end

    assign out_s.valid = rd_valid_q;
    assign out_s.data  = rd_data_q;

    // output strobe follows an accepted sample by one cycle.
    out_after_in_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_s.valid |-> $past(in_s.valid)
    );

    // steering must not move in the middle of a block.
    orient_stable_in_block_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (idx != '0) |-> $stable(steer.orient)
    );

endmodule

// ==== dv/tb_block_transposer.sv ====
`timescale 1ns/1ps
`include "block_transposer_macros.svh"

module tb_block_transposer;

    localparam int BLK_LEN      = `BT_BLK_DIM * `BT_BLK_DIM;
    localparam int FILE_BLOCKS  = 2;
    localparam int RAND_BLOCKS  = 4;   // last one only flushes.
    localparam int MAX_GAP      = 3;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 200;
    localparam int TOTAL_IN     = (FILE_BLOCKS + RAND_BLOCKS) * BLK_LEN;
    localparam int CYCLE_LIMIT  = TOTAL_IN * (MAX_GAP + 1) + RESET_CYCLES + MARGIN;
    localparam logic [31:0] LFSR_SEED = 32'hf445;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                          clk;
    logic                          rst_n;
    block_transposer_pkg::sample_t in_s;
    block_transposer_pkg::sample_t out_s;

    // gap, input, expected word and flag per sample.
    logic [15:0]                   tdata [0:FILE_BLOCKS*BLK_LEN*4-1];
    block_transposer_pkg::data_t   prev_blk [BLK_LEN];
    block_transposer_pkg::data_t   cur_blk [BLK_LEN];
    block_transposer_pkg::data_t   exp_q [$];
    logic [31:0]                   lfsr;
    int                            blk_pos;
    int                            in_cnt;
    int                            out_cnt;
    int                            err_cnt;
    int                            err_base;
    int                            tests_run;
    int                            tests_failed;
    int                            cycles;
    logic                          pend_valid;
    logic                          pend_primed;

    block_transposer dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (in_s),
        .out_s (out_s)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s >> 1;
        if (s[0])
        begin
            lfsr_next = lfsr_next ^ LFSR_TAPS;
        end
    endfunction

    // one step per bit taken.
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // output j of a block is row j mod 8 and column j div 8 of the block before.
    function automatic block_transposer_pkg::data_t transposed_word(input int j);
        transposed_word = prev_blk[(j % `BT_BLK_DIM) * `BT_BLK_DIM + j / `BT_BLK_DIM];
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       test_name = "file block transposed";
            2:       test_name = "back-to-back block";
            3, 4:    test_name = "random gap block";
            5:       test_name = "flush of last random block";
            default: test_name = "extra block";
        endcase
    endfunction

    task automatic report_test(input string name);
        tests_run++;
        if (err_cnt == err_base)
        begin
            $display("test %0d %s: ok", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    task automatic drive_sample(input int gap, input block_transposer_pkg::data_t d,
                                input logic has_exp, input block_transposer_pkg::data_t exp_word);
        block_transposer_pkg::sample_t s;
        repeat (gap)
        begin
            @(posedge clk);
            in_s <= '0;
        end
        @(posedge clk);
        s.valid = 1'b1;
        s.data  = d;
        in_s <= s;
        if (has_exp)
        begin
            exp_q.push_back(exp_word);
        end
        cur_blk[blk_pos] = d;
        blk_pos++;
        if (blk_pos == BLK_LEN)
        begin
            prev_blk = cur_blk;
            blk_pos  = 0;
        end
    endtask

    // strobe and data are checked half a cycle after the edge.
    always @(negedge clk)
    begin
        logic                        exp_valid;
        block_transposer_pkg::data_t exp_word;
        if (rst_n)
        begin
            exp_valid = pend_valid && pend_primed;
            if (out_s.valid !== exp_valid)
            begin
                $display("MISMATCH out_s.valid: expected %h, actual %h", exp_valid, out_s.valid);
                err_cnt++;
            end
            if (out_s.valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("output word %h arrived with no expected word left", out_s.data);
                    err_cnt++;
                end
                else
                begin
                    exp_word = exp_q.pop_front();
                    if (out_s.data !== exp_word)
                    begin
                        $display("MISMATCH out_s.data: expected %h, actual %h",
                                 exp_word, out_s.data);
                        err_cnt++;
                    end
                end
                out_cnt++;
                if (out_cnt % BLK_LEN == 0)
                begin
                    report_test(test_name(out_cnt / BLK_LEN));
                end
            end
            if (pend_valid && in_cnt == BLK_LEN)
            begin
                report_test("first block stays silent");
            end
            pend_valid  = in_s.valid;
            pend_primed = (in_cnt >= BLK_LEN);
            if (in_s.valid === 1'b1)
            begin
                in_cnt++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: outputs still missing after %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        int                          base;
        int                          g;
        logic [31:0]                 r;
        block_transposer_pkg::data_t d;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_s         = '0;
        lfsr         = LFSR_SEED;
        blk_pos      = 0;
        in_cnt       = 0;
        out_cnt      = 0;
        err_cnt      = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        pend_valid   = 1'b0;
        pend_primed  = 1'b0;
        $readmemh("dv/transposer_testdata.hex", tdata);
        if ($isunknown(tdata[1]))
        begin
            $display("test data file could not be read");
            err_cnt++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < FILE_BLOCKS * BLK_LEN; k++)
        begin
            base = k * 4;
            if (tdata[base+3][0] && tdata[base+2] !== transposed_word(blk_pos))
            begin
                $display("test data sample %0d holds a word that breaks the transpose rule", k);
                err_cnt++;
            end
            drive_sample(int'(tdata[base]), tdata[base+1], tdata[base+3][0], tdata[base+2]);
        end

        for (int b = 0; b < RAND_BLOCKS; b++)
        begin
            for (int k = 0; k < BLK_LEN; k++)
            begin
                rand_bits(16, r);
                d = r[15:0];
                g = 0;
                if (b != 0)
                begin
                    rand_bits(2, r);
                    g = int'(r[1:0]);
                end
                drive_sample(g, d, 1'b1, transposed_word(blk_pos));   // first one runs gapless.
            end
        end
        @(posedge clk);
        in_s <= '0;

        while (out_cnt < TOTAL_IN - BLK_LEN) @(posedge clk);
        repeat (4) @(posedge clk);   // stray strobes would show in this quiet tail.
        if (out_cnt != in_cnt - BLK_LEN || exp_q.size() != 0)
        begin
            $display("output count %0d does not match %0d inputs less one block", out_cnt, in_cnt);
            err_cnt++;
        end
        report_test("output count");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/transposer_testdata.hex ====
// columns: idle gap before sample, input word, expected output word, expect flag
// block 0 fills the buffer, block 1 follows with no gap and streams block 0 out transposed
0 a000 0000 0
0 a001 0000 0
0 a002 0000 0
0 a003 0000 0
0 a004 0000 0
1 a005 0000 0
0 a006 0000 0
0 a007 0000 0
0 a010 0000 0
0 a011 0000 0
0 a012 0000 0
0 a013 0000 0
2 a014 0000 0
0 a015 0000 0
0 a016 0000 0
0 a017 0000 0
0 a020 0000 0
0 a021 0000 0
0 a022 0000 0
3 a023 0000 0
0 a024 0000 0
0 a025 0000 0
0 a026 0000 0
0 a027 0000 0
0 a030 0000 0
0 a031 0000 0
1 a032 0000 0
0 a033 0000 0
0 a034 0000 0
0 a035 0000 0
0 a036 0000 0
0 a037 0000 0
0 a040 0000 0
2 a041 0000 0
0 a042 0000 0
0 a043 0000 0
0 a044 0000 0
0 a045 0000 0
0 a046 0000 0
0 a047 0000 0
3 a050 0000 0
0 a051 0000 0
0 a052 0000 0
0 a053 0000 0
0 a054 0000 0
0 a055 0000 0
0 a056 0000 0
1 a057 0000 0
0 a060 0000 0
0 a061 0000 0
0 a062 0000 0
0 a063 0000 0
0 a064 0000 0
0 a065 0000 0
2 a066 0000 0
0 a067 0000 0
0 a070 0000 0
0 a071 0000 0
0 a072 0000 0
0 a073 0000 0
0 a074 0000 0
3 a075 0000 0
0 a076 0000 0
0 a077 0000 0
0 b000 a000 1
0 b001 a010 1
0 b002 a020 1
0 b003 a030 1
0 b004 a040 1
0 b005 a050 1
0 b006 a060 1
0 b007 a070 1
0 b010 a001 1
0 b011 a011 1
0 b012 a021 1
0 b013 a031 1
0 b014 a041 1
0 b015 a051 1
0 b016 a061 1
0 b017 a071 1
0 b020 a002 1
0 b021 a012 1
0 b022 a022 1
0 b023 a032 1
0 b024 a042 1
0 b025 a052 1
0 b026 a062 1
0 b027 a072 1
0 b030 a003 1
0 b031 a013 1
0 b032 a023 1
0 b033 a033 1
0 b034 a043 1
0 b035 a053 1
0 b036 a063 1
0 b037 a073 1
0 b040 a004 1
0 b041 a014 1
0 b042 a024 1
0 b043 a034 1
0 b044 a044 1
0 b045 a054 1
0 b046 a064 1
0 b047 a074 1
0 b050 a005 1
0 b051 a015 1
0 b052 a025 1
0 b053 a035 1
0 b054 a045 1
0 b055 a055 1
0 b056 a065 1
0 b057 a075 1
0 b060 a006 1
0 b061 a016 1
0 b062 a026 1
0 b063 a036 1
0 b064 a046 1
0 b065 a056 1
0 b066 a066 1
0 b067 a076 1
0 b070 a007 1
0 b071 a017 1
0 b072 a027 1
0 b073 a037 1
0 b074 a047 1
0 b075 a057 1
0 b076 a067 1
0 b077 a077 1

// ==== vlog.f ====
+incdir+design
design/block_transposer_pkg.sv
design/elem_counter.sv
design/transpose_ctrl.sv
design/transpose_ram.sv
design/block_transposer.sv
dv/tb_block_transposer.sv
